/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps
TOP       = ntps_tb
FILELIST  = ntps_regs.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# Build and run; the status comes from the search for the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* design/ntps_bus_pkg.sv */
/*
 Types of the host register bus: request, response and the decoded
 form of an accepted access that the register banks work from.
*/

`include "ntps_settings.svh"

package ntps_bus_pkg;

  //--------------------------------------------------
  // Host side
  //--------------------------------------------------
  typedef struct packed {
    logic                       write;
    logic [`NTPS_ADDR_W-1:0]    addr;
    logic [`NTPS_DATA_W-1:0]    wdata;
    logic [`NTPS_DATA_W/8-1:0]  strb;
  } bus_req_t;

  // Same codes as the AXI xRESP field
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2
  } resp_code_t;

  typedef struct packed {
    resp_code_t                 code;
    logic [`NTPS_DATA_W-1:0]    data;
  } bus_resp_t;

  //--------------------------------------------------
  // Decoded access
  //--------------------------------------------------
  typedef logic [$clog2(`NTPS_NUM_PORTS)-1:0] port_idx_t;
  typedef logic [`NTPS_WORD_W-1:0]            word_idx_t;

  typedef struct packed {
    logic                       fire;
    logic                       write;
    port_idx_t                  port;
    word_idx_t                  word;
    logic                       error;
    logic [`NTPS_DATA_W-1:0]    wdata;
    logic [`NTPS_DATA_W/8-1:0]  strb;
  } decoded_t;

endpackage

/* design/ntps_clock_select.sv */
/*
 Common time-source select. Registers the time and sync flag of the
 chosen source whenever that source signals an update.
*/

module ntps_clock_select
  import ntps_port_pkg::*;
(
  input  logic      axi_aclk,
  input  logic      arst_n,
  input  logic      select,
  input  time_src_t time_a,
  input  time_src_t time_b,
  output ntp_time_t ntp_time,
  output logic      ntp_sync_ok
);

  time_src_t src;

  // Low picks A, high picks B
  assign src = select ? time_b : time_a;

  // Update pulse of the other source has no effect
  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      ntp_time    <= '0;
      ntp_sync_ok <= 1'b0;
    end else if (src.upd) begin
      ntp_time    <= src.ntp_time;
      ntp_sync_ok <= src.sync_ok;
    end
  end

endmodule

/* design/ntps_interfaces.sv */
/*
 Top level of the register side: the host bus decode, four
 network-path register banks in slots 3 to 6, the response path and
 the common time-source select driven from port 0.
*/

`include "ntps_settings.svh"

module ntps_interfaces
  import ntps_bus_pkg::*;
  import ntps_port_pkg::*;
(
  input  logic                    axi_aclk,
  input  logic                    arst_n,

  // Host request
  input  logic                    req_valid,
  input  bus_req_t                req,
  output logic                    req_ready,

  // Host response
  output logic                    rsp_valid,
  output bus_resp_t               rsp,
  input  logic                    rsp_ready,

  // Network paths
  output port_config_t            port_cfg  [`NTPS_NUM_PORTS],
  input  logic [`NTPS_DATA_W-1:0] pp_status [`NTPS_NUM_PORTS],

  // Time sources
  input  time_src_t               time_a,
  input  time_src_t               time_b,
  output ntp_time_t               ntp_time
);

  decoded_t                   dec;
  logic [`NTPS_NUM_PORTS-1:0] port_we;
  logic [`NTPS_DATA_W-1:0]    rd_words [`NTPS_NUM_PORTS];
  logic                       ntp_sync_ok;

  //--------------------------------------------------
  // Address decode
  //--------------------------------------------------
  ntps_slot_decode slot_decode0 (
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready),
    .dec       (dec),
    .port_we   (port_we)
  );

  //--------------------------------------------------
  // Network-path register banks
  //--------------------------------------------------
  for (genvar i = 0; i < `NTPS_NUM_PORTS; i++) begin : g_port
    ntps_port_regs port_regs0 (
      .axi_aclk    (axi_aclk),
      .arst_n      (arst_n),
      .dec         (dec),
      .we          (port_we[i]),
      .pp_status   (pp_status[i]),
      .ntp_sync_ok (ntp_sync_ok),
      .cfg         (port_cfg[i]),
      .rd_data     (rd_words[i])
    );
  end

  //--------------------------------------------------
  // Time select, controlled from port 0
  //--------------------------------------------------
  ntps_clock_select clock_select0 (
    .axi_aclk    (axi_aclk),
    .arst_n      (arst_n),
    .select      (port_cfg[0].gen_config[`NTPS_SEL_BIT]),
    .time_a      (time_a),
    .time_b      (time_b),
    .ntp_time    (ntp_time),
    .ntp_sync_ok (ntp_sync_ok)
  );

  //--------------------------------------------------
  // Response path
  //--------------------------------------------------
  ntps_read_return read_return0 (
    .axi_aclk  (axi_aclk),
    .arst_n    (arst_n),
    .dec       (dec),
    .rd_words  (rd_words),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .rsp_ready (rsp_ready)
  );

endmodule

/* design/ntps_port_pkg.sv */
/*
 Types of the network-path side: the configuration words a port
 drives and the time stamps coming from the two time sources.
*/

`include "ntps_settings.svh"

package ntps_port_pkg;

  //--------------------------------------------------
  // Per-port configuration
  //--------------------------------------------------
  typedef struct packed {
    logic [`NTPS_DATA_W-1:0]   gen_config;
    logic [`NTPS_DATA_W-1:0]   ntp_config;
    logic [`NTPS_DATA_W-1:0]   root_delay;
    logic [`NTPS_DATA_W-1:0]   root_disp;
    logic [`NTPS_DATA_W-1:0]   ref_id;
    // Upper half from REF_TS_HI, lower half from REF_TS_LO
    logic [2*`NTPS_DATA_W-1:0] ref_ts;
    logic [`NTPS_DATA_W-1:0]   rx_ofs;
    logic [`NTPS_DATA_W-1:0]   tx_ofs;
  } port_config_t;

  //--------------------------------------------------
  // Time sources
  //--------------------------------------------------
  // NTP format, seconds in the upper 32 bits
  typedef logic [63:0] ntp_time_t;

  // One time source as seen by the select
  typedef struct packed {
    ntp_time_t ntp_time;
    logic      upd;
    logic      sync_ok;
  } time_src_t;

endpackage

/* design/ntps_port_regs.sv */
/*
 Register bank of one network path. Holds the nine writable
 configuration words with byte-strobed writes and returns any legal
 word, status included, as a combinational read word.
*/

`include "ntps_settings.svh"

module ntps_port_regs
  import ntps_bus_pkg::*;
  import ntps_port_pkg::*;
(
  input  logic                    axi_aclk,
  input  logic                    arst_n,
  input  decoded_t                dec,
  input  logic                    we,
  input  logic [`NTPS_DATA_W-1:0] pp_status,
  input  logic                    ntp_sync_ok,
  output port_config_t            cfg,
  output logic [`NTPS_DATA_W-1:0] rd_data
);

  // Writable words are 0..TX_OFS
  localparam int NUM_WR = `NTPS_W_TX_OFS + 1;
  localparam int NUM_BYTES = `NTPS_DATA_W / 8;

  logic [`NTPS_DATA_W-1:0] regs [NUM_WR];

  //--------------------------------------------------
  // Write side
  //--------------------------------------------------
  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_WR; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      // Decode never enables a write above TX_OFS
      for (int i = 0; i < NUM_WR; i++) begin
        if (dec.word == word_idx_t'(i)) begin
          for (int b = 0; b < NUM_BYTES; b++) begin
            if (dec.strb[b]) begin
              regs[i][8*b +: 8] <= dec.wdata[8*b +: 8];
            end
          end
        end
      end
    end
  end

  //--------------------------------------------------
  // Configuration outputs
  //--------------------------------------------------
  always_comb begin
    cfg.gen_config = regs[`NTPS_W_GEN_CONFIG];
    cfg.ntp_config = regs[`NTPS_W_NTP_CONFIG];
    cfg.root_delay = regs[`NTPS_W_ROOT_DELAY];
    cfg.root_disp  = regs[`NTPS_W_ROOT_DISP];
    cfg.ref_id     = regs[`NTPS_W_REF_ID];
    cfg.ref_ts     = {regs[`NTPS_W_REF_TS_HI], regs[`NTPS_W_REF_TS_LO]};
    cfg.rx_ofs     = regs[`NTPS_W_RX_OFS];
    cfg.tx_ofs     = regs[`NTPS_W_TX_OFS];
  end

  //--------------------------------------------------
  // Read mux
  //--------------------------------------------------
  always_comb begin
    rd_data = '0;
    for (int i = 0; i < NUM_WR; i++) begin
      if (dec.word == word_idx_t'(i)) begin
        rd_data = regs[i];
      end
    end
    if (dec.word == word_idx_t'(`NTPS_W_PP_STATUS)) begin
      rd_data = pp_status;
    end
    // Sync flag sits alone in bit 0
    if (dec.word == word_idx_t'(`NTPS_W_SYNC_OK)) begin
      rd_data = {{(`NTPS_DATA_W-1){1'b0}}, ntp_sync_ok};
    end
  end

endmodule

/* design/ntps_read_return.sv */
/*
 Response side of the bus. Captures the response on the accepting
 edge, holds it until the host takes it and only then lets the next
 request in, so one access is in flight at a time.
*/

`include "ntps_settings.svh"

module ntps_read_return
  import ntps_bus_pkg::*;
(
  input  logic                    axi_aclk,
  input  logic                    arst_n,
  input  decoded_t                dec,
  input  logic [`NTPS_DATA_W-1:0] rd_words [`NTPS_NUM_PORTS],
  output logic                    req_ready,
  output logic                    rsp_valid,
  output bus_resp_t               rsp,
  input  logic                    rsp_ready
);

  bus_resp_t rsp_next;

  // Errors and writes carry zero data, reads carry the port's word
  always_comb begin
    if (dec.error) begin
      rsp_next.code = RESP_SLVERR;
      rsp_next.data = '0;
    end else begin
      rsp_next.code = RESP_OKAY;
      rsp_next.data = dec.write ? '0 : rd_words[dec.port];
    end
  end

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_valid <= 1'b0;
    end else if (dec.fire) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  // Held unchanged under back-pressure
  always_ff @(posedge axi_aclk) begin
    if (dec.fire) begin
      rsp <= rsp_next;
    end
  end

  // No new request while a response is outstanding
  assign req_ready = !rsp_valid;

endmodule

/* design/ntps_settings.svh */
/*
 Widths, slot numbers and register word offsets of the time server
 register side. Included by every file that needs one of them.
*/

`ifndef NTPS_SETTINGS_SVH
`define NTPS_SETTINGS_SVH

`define NTPS_NUM_PORTS 4
`define NTPS_NUM_SLOTS 12
`define NTPS_SLOT_NP0  3

`define NTPS_DATA_W   32
`define NTPS_ADDR_W   16
`define NTPS_SLOT_LSB 12
`define NTPS_WORD_LSB 2
`define NTPS_WORD_W   4

// Port 0 gen_config bit that picks time source B
`define NTPS_SEL_BIT 24

// Word offsets inside one network-path slot
`define NTPS_W_GEN_CONFIG 0
`define NTPS_W_NTP_CONFIG 1
`define NTPS_W_ROOT_DELAY 2
`define NTPS_W_ROOT_DISP  3
`define NTPS_W_REF_ID     4
`define NTPS_W_REF_TS_HI  5
`define NTPS_W_REF_TS_LO  6
`define NTPS_W_RX_OFS     7
`define NTPS_W_TX_OFS     8
`define NTPS_W_PP_STATUS  9
`define NTPS_W_SYNC_OK    10

`endif

/* design/ntps_slot_decode.sv */
/*
 Splits an accepted bus request into slot, port and word, flags every
 access that has no legal target and forms the per-port write enables.
*/

`include "ntps_settings.svh"

module ntps_slot_decode
  import ntps_bus_pkg::*;
(
  input  logic                       req_valid,
  input  bus_req_t                   req,
  input  logic                       req_ready,
  output decoded_t                   dec,
  output logic [`NTPS_NUM_PORTS-1:0] port_we
);

  localparam int SLOT_W = $clog2(`NTPS_NUM_SLOTS);

  logic [SLOT_W-1:0] slot;
  word_idx_t         word;
  logic              slot_ok;
  logic              word_ok;
  logic              ro_word;

  assign slot = req.addr[`NTPS_SLOT_LSB +: SLOT_W];
  assign word = req.addr[`NTPS_WORD_LSB +: `NTPS_WORD_W];

  // Only slots NP0..NP3 hold register banks
  assign slot_ok = (slot >= SLOT_W'(`NTPS_SLOT_NP0)) &&
                   (slot <  SLOT_W'(`NTPS_SLOT_NP0 + `NTPS_NUM_PORTS));
  assign word_ok = (word <= word_idx_t'(`NTPS_W_SYNC_OK));
  assign ro_word = (word == word_idx_t'(`NTPS_W_PP_STATUS)) ||
                   (word == word_idx_t'(`NTPS_W_SYNC_OK));

  always_comb begin
    dec.fire  = req_valid && req_ready;
    dec.write = req.write;
    dec.port  = port_idx_t'(slot - SLOT_W'(`NTPS_SLOT_NP0));
    dec.word  = word;
    dec.error = !slot_ok || !word_ok || (req.write && ro_word);
    dec.wdata = req.wdata;
    dec.strb  = req.strb;
  end

  // One-hot enable, only for a legal write that fires
  always_comb begin
    port_we = '0;
    for (int i = 0; i < `NTPS_NUM_PORTS; i++) begin
      if (dec.fire && dec.write && !dec.error && (dec.port == port_idx_t'(i))) begin
        port_we[i] = 1'b1;
      end
    end
  end

endmodule

/* ntps_regs.f */
+incdir+design
design/ntps_bus_pkg.sv
design/ntps_port_pkg.sv
design/ntps_slot_decode.sv
design/ntps_port_regs.sv
design/ntps_clock_select.sv
design/ntps_read_return.sv
design/ntps_interfaces.sv
verification/ntps_tb.sv

/* verification/ntps_tb.sv */
/*
 Testbench of the time server register side. Drives the host bus on
 the falling clock edge, predicts every response and configuration
 word from a model, and checks the time-source select.
*/

`include "ntps_settings.svh"

module ntps_tb
  import ntps_bus_pkg::*;
  import ntps_port_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 40;
  localparam int NP = `NTPS_NUM_PORTS;
  localparam int NP0 = `NTPS_SLOT_NP0;
  // Requests of all tests, in run order
  localparam int TOTAL_REQ = 44 + 84 + 16 + 64 + 6 + 60;

  logic         axi_aclk = 1'b0;
  logic         arst_n;
  logic         req_valid;
  bus_req_t     req;
  logic         req_ready;
  logic         rsp_valid;
  bus_resp_t    rsp;
  logic         rsp_ready = 1'b1;
  port_config_t port_cfg [NP];
  logic [31:0]  pp_status [NP];
  time_src_t    time_a;
  time_src_t    time_b;
  ntp_time_t    ntp_time;

  // Model and bookkeeping
  port_config_t model [NP];
  ntp_time_t    model_time = '0;
  logic         model_sync = 1'b0;
  bus_resp_t    exp_arr [TOTAL_REQ];
  int           n_sent = 0;
  int           n_taken = 0;
  logic         bp_on = 1'b0;
  logic [2:0]   stall = 3'd0;
  logic         held = 1'b0;
  bus_resp_t    held_rsp;
  logic [31:0]  stim_lfsr = 32'h464a36ca;
  logic [31:0]  bp_lfsr = 32'h464a36ca;
  string        cur_test = "none";
  int           errors = 0;
  int           cmp_errors = 0;
  int           test_start = 0;
  int           n_tests = 0;
  int           n_failed = 0;

  ntps_interfaces dut0 (.*);

  always #(CLK_PERIOD / 2) axi_aclk = ~axi_aclk;

  //--------------------------------------------------
  // Random numbers and reference model
  //--------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_next(stim_lfsr);
      v = {v[30:0], stim_lfsr[0]};
    end
    return v;
  endfunction

  // Word 0 is the most significant word of port_config_t
  function automatic int word_lsb(input int w);
    return 32 * (`NTPS_W_TX_OFS - w);
  endfunction

  function automatic bus_resp_t ref_resp(input bus_req_t r);
    int        slot;
    int        w;
    bus_resp_t e;
    slot = int'(r.addr[`NTPS_SLOT_LSB +: 4]);
    w = int'(r.addr[`NTPS_WORD_LSB +: 4]);
    e.code = RESP_OKAY;
    e.data = '0;
    if (slot < NP0 || slot >= NP0 + NP || w > `NTPS_W_SYNC_OK ||
        (r.write && w >= `NTPS_W_PP_STATUS)) begin
      e.code = RESP_SLVERR;
    end else if (!r.write && w == `NTPS_W_PP_STATUS) begin
      e.data = pp_status[slot - NP0];
    end else if (!r.write && w == `NTPS_W_SYNC_OK) begin
      e.data = {31'd0, model_sync};
    end else if (!r.write) begin
      e.data = model[slot - NP0][word_lsb(w) +: 32];
    end
    return e;
  endfunction

  //--------------------------------------------------
  // Compare tasks
  //--------------------------------------------------
  task automatic check_resp(input bus_resp_t exp, input bus_resp_t act);
    if (act !== exp) begin
      $display("error %s: expected code %0d data %08h, actual code %0d data %08h",
               cur_test, exp.code, exp.data, act.code, act.data);
      cmp_errors++;
    end
  endtask

  task automatic check_cfg(input int p, input port_config_t exp, input port_config_t act);
    if (act !== exp) begin
      $display("error %s: port %0d config expected %h actual %h", cur_test, p, exp, act);
      errors++;
    end
  endtask

  task automatic check_time(input ntp_time_t exp, input ntp_time_t act);
    if (act !== exp) begin
      $display("error %s: ntp_time expected %016h actual %016h", cur_test, exp, act);
      errors++;
    end
  endtask

  //--------------------------------------------------
  // Bus stimulus
  //--------------------------------------------------
  task automatic send(input logic wr, input int slot, input int w,
                      input logic [31:0] data, input logic [3:0] strb);
    bus_req_t r;
    r = '0;
    r.write = wr;
    r.addr[`NTPS_SLOT_LSB +: 4] = slot[3:0];
    r.addr[`NTPS_WORD_LSB +: 4] = w[3:0];
    r.wdata = data;
    r.strb = strb;
    exp_arr[n_sent] = ref_resp(r);
    if (wr && exp_arr[n_sent].code == RESP_OKAY) begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
          model[slot - NP0][word_lsb(w) + 8 * b +: 8] = data[8 * b +: 8];
        end
      end
    end
    n_sent++;
    req = r;
    req_valid = 1'b1;
    while (!req_ready) @(negedge axi_aclk);
    @(negedge axi_aclk);
    req_valid = 1'b0;
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_start = errors + cmp_errors;
  endtask

  // Drain all responses, then compare every port's configuration
  task automatic end_test();
    while (n_taken != n_sent) @(negedge axi_aclk);
    @(negedge axi_aclk);
    for (int p = 0; p < NP; p++) begin
      check_cfg(p, model[p], port_cfg[p]);
    end
    n_tests++;
    if (errors + cmp_errors == test_start) begin
      $display("test %s passed", cur_test);
    end else begin
      n_failed++;
      $display("test %s failed with %0d errors", cur_test, errors + cmp_errors - test_start);
    end
  endtask

  // Random pulses on both sources, only the selected one may land
  task automatic run_select(input logic sel);
    time_src_t   a;
    time_src_t   b;
    logic [3:0]  r;
    logic [31:0] d;
    d = rand_bits(32);
    d[`NTPS_SEL_BIT] = sel;
    send(1'b1, NP0, `NTPS_W_GEN_CONFIG, d, 4'hf);
    repeat (32) begin
      a.ntp_time = {rand_bits(32), rand_bits(32)};
      b.ntp_time = {rand_bits(32), rand_bits(32)};
      r = 4'(rand_bits(4));
      a.upd = r[0];
      a.sync_ok = r[1];
      b.upd = r[2];
      b.sync_ok = r[3];
      time_a = a;
      time_b = b;
      if (sel ? b.upd : a.upd) begin
        model_time = sel ? b.ntp_time : a.ntp_time;
        model_sync = sel ? b.sync_ok : a.sync_ok;
      end
      @(negedge axi_aclk);
      check_time(model_time, ntp_time);
    end
    time_a.upd = 1'b0;
    time_b.upd = 1'b0;
    send(1'b0, NP0, `NTPS_W_SYNC_OK, '0, '0);
    send(1'b0, NP0 + NP - 1, `NTPS_W_SYNC_OK, '0, '0);
  endtask

  //--------------------------------------------------
  // Response compare and back-pressure
  //--------------------------------------------------
  always @(negedge axi_aclk) begin
    if (arst_n) begin
      if (held && (!rsp_valid || rsp !== held_rsp)) begin
        $display("%s: response changed or dropped while held back", cur_test);
        cmp_errors++;
      end
      if (rsp_valid && req_ready) begin
        $display("%s: request ready is high while a response is pending", cur_test);
        cmp_errors++;
      end
      // Low stretches of 0 to 7 cycles between single ready cycles
      if (bp_on && stall != 3'd0) begin
        rsp_ready = 1'b0;
        stall = stall - 3'd1;
      end else begin
        rsp_ready = 1'b1;
        for (int i = 0; i < 3; i++) begin
          bp_lfsr = lfsr_next(bp_lfsr);
          stall = {stall[1:0], bp_lfsr[0]};
        end
      end
      // Ready driven here decides the coming rising edge
      held = rsp_valid && !rsp_ready;
      held_rsp = rsp;
      if (rsp_valid && rsp_ready) begin
        if (n_taken >= n_sent) begin
          $display("%s: response arrived with no request outstanding", cur_test);
          cmp_errors++;
        end else begin
          check_resp(exp_arr[n_taken], rsp);
          n_taken++;
        end
      end
    end
  end

  //--------------------------------------------------
  // Test sequence
  //--------------------------------------------------
  initial begin
    int          slot;
    int          w;
    logic [31:0] d;
    logic [3:0]  s;
    arst_n = 1'b0;
    req_valid = 1'b0;
    req = '0;
    time_a = '0;
    time_b = '0;
    for (int p = 0; p < NP; p++) begin
      pp_status[p] = rand_bits(32);
      model[p] = '0;
    end
    repeat (5) @(negedge axi_aclk);
    arst_n = 1'b1;
    @(negedge axi_aclk);

    start_test("reset");
    check_time(model_time, ntp_time);
    for (int p = 0; p < NP; p++) begin
      for (int i = 0; i <= `NTPS_W_SYNC_OK; i++) begin
        send(1'b0, NP0 + p, i, '0, '0);
      end
    end
    end_test();

    start_test("random_rw");
    repeat (48) begin
      slot = NP0 + int'(rand_bits(2));
      w = int'(rand_bits(4)) % (`NTPS_W_TX_OFS + 1);
      d = rand_bits(32);
      s = 4'(rand_bits(4));
      send(1'b1, slot, w, d, s);
    end
    for (int p = 0; p < NP; p++) begin
      for (int i = 0; i <= `NTPS_W_TX_OFS; i++) begin
        send(1'b0, NP0 + p, i, '0, '0);
      end
    end
    end_test();

    start_test("read_only");
    for (int p = 0; p < NP; p++) begin
      send(1'b0, NP0 + p, `NTPS_W_PP_STATUS, '0, '0);
      send(1'b1, NP0 + p, `NTPS_W_PP_STATUS, rand_bits(32), 4'hf);
      send(1'b1, NP0 + p, `NTPS_W_SYNC_OK, rand_bits(32), 4'hf);
      send(1'b0, NP0 + p, `NTPS_W_SYNC_OK, '0, '0);
    end
    end_test();

    start_test("unmapped");
    for (int sl = 0; sl < 16; sl++) begin
      if (sl < NP0 || sl >= NP0 + NP) begin
        d = rand_bits(32);
        send(1'b1, sl, int'(rand_bits(4)), d, 4'hf);
        send(1'b0, sl, int'(rand_bits(4)), '0, '0);
      end
    end
    for (int p = 0; p < NP; p++) begin
      for (int i = `NTPS_W_SYNC_OK + 1; i < 16; i++) begin
        send(1'b1, NP0 + p, i, rand_bits(32), 4'hf);
        send(1'b0, NP0 + p, i, '0, '0);
      end
    end
    end_test();

    start_test("time_select");
    run_select(1'b0);
    run_select(1'b1);
    end_test();

    start_test("back_pressure");
    bp_on = 1'b1;
    repeat (60) begin
      d = rand_bits(12);
      slot = d[0] ? NP0 + int'(d[2:1]) : int'(d[6:3]);
      w = int'(d[10:7]);
      s = 4'(rand_bits(4));
      send(d[11], slot, w, rand_bits(32), s);
    end
    end_test();
    bp_on = 1'b0;

    $display("%0d tests run, %0d failed, %0d checks failed",
             n_tests, n_failed, errors + cmp_errors);
    if (errors + cmp_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog, 20 clock periods per request
  initial begin
    #(CLK_PERIOD * TOTAL_REQ * 20);
    $display("timeout: only %0d of %0d responses arrived in time", n_taken, n_sent);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule
